//--- filelist.f
source/privPkg.sv
source/statusPkg.sv
source/statusReg.sv
source/privTracker.sv
source/csrAccess.sv
source/csrUnit.sv
tests/csrUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the csrUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module csrUnitTb -f filelist.f -o csrUnitSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/csrUnitSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

//--- tests/csrUnitTb.sv
`default_nettype none

module csrUnitTb;

  import privPkg::*;
  import statusPkg::*;

  localparam int clkPeriod      = 100;
  localparam int resetCycles    = 16;
  localparam int randomOps      = 40;
  localparam int endianRounds   = 8;
  localparam int directedCycles = 60; // traps, returns, illegal and stall sections
  localparam int stimCycles     = resetCycles + randomOps + endianRounds * 6 + directedCycles;
  localparam int watchdogTime   = (stimCycles + 20) * clkPeriod;

  logic clk, reset, csrValid, trap, mret, sret, fpWrite, stall, hptwAccess;
  csrOp_t      csrOp;
  logic [11:0] csrAddr;
  logic [31:0] csrSrc;
  logic [4:0]  cause;
  logic [31:0] csrRdata, mstatusWord, mstatushWord, sstatusWord;
  logic        illegalCsr, statusMie, statusSie, statusMprv, bigEndian;
  privMode_t   privMode, statusMpp;
  logic [1:0]  statusFs;

  // reference model state
  logic        refMie, refSie, refMpie, refSpie, refSpp, refMprv;
  logic        refTsr, refTw, refTvm, refMxr, refSum, refUbe, refMbe, refSbe;
  logic [1:0]  refFs;
  privMode_t   refMpp, refMode, trapTarget, beMode;
  logic [31:0] refMedeleg, expRead, expWval, lcgState;
  logic        expIllegal, expBe, expWrite;
  statusWord_u expMs, expSs, expMsh, wv;
  int          errors;

  csrUnit #(
    .sSupported(1'b1), .uSupported(1'b1), .fpSupported(1'b1), .bigEndianSupported(1'b1)
  ) u_csrUnit (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // lcg step with the numerical recipes constants
  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  ////////////////////
  // expected values
  ////////////////////

  always_comb begin
    expMs = '0;
    expMs.ms.sd = (refFs == fsDirty);
    {expMs.ms.tsr, expMs.ms.tw, expMs.ms.tvm} = {refTsr, refTw, refTvm};
    {expMs.ms.mxr, expMs.ms.sum, expMs.ms.mprv} = {refMxr, refSum, refMprv};
    expMs.ms.fs  = refFs;
    expMs.ms.mpp = refMpp;
    {expMs.ms.spp, expMs.ms.mpie, expMs.ms.ube} = {refSpp, refMpie, refUbe};
    {expMs.ms.spie, expMs.ms.mie, expMs.ms.sie} = {refSpie, refMie, refSie};
    expSs = '0; // supervisor subset only
    expSs.ms.sd = (refFs == fsDirty);
    {expSs.ms.mxr, expSs.ms.sum, expSs.ms.fs} = {refMxr, refSum, refFs};
    {expSs.ms.spp, expSs.ms.ube, expSs.ms.spie, expSs.ms.sie} = {refSpp, refUbe, refSpie, refSie};
    expMsh = '0;
    {expMsh.msh.mbe, expMsh.msh.sbe} = {refMbe, refSbe};
    case (csrAddr)
      addrMstatus:  expRead = expMs;
      addrMstatush: expRead = expMsh;
      addrSstatus:  expRead = expSs;
      addrMedeleg:  expRead = refMedeleg;
      default:      expRead = '0;
    endcase
    expIllegal = csrValid && (!(csrAddr inside {addrMstatus, addrMstatush, addrSstatus,
                 addrMedeleg}) || refMode < csrAddr[9:8]); // bits 9:8 = lowest mode
    case (csrOp)
      opWrite: expWval = csrSrc;
      opSet:   expWval = expRead | csrSrc;
      opClear: expWval = expRead & ~csrSrc;
      default: expWval = expRead;
    endcase
    wv = expWval;
    expWrite = csrValid && !expIllegal && (csrOp == opWrite || (csrOp != opNone && csrSrc != 0));
    trapTarget = (refMode != privMachine && refMedeleg[cause]) ? privSuper : privMachine;
    if (hptwAccess) beMode = privSuper;                          // page walker is s mode
    else if (refMode == privMachine && refMprv) beMode = refMpp; // mprv in m mode
    else beMode = refMode;
    case (beMode)
      privMachine: expBe = refMbe;
      privSuper:   expBe = refSbe;
      default:     expBe = refUbe;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      {refMie, refSie, refMpie, refSpie, refSpp, refMprv} <= '0;
      {refTsr, refTw, refTvm, refMxr, refSum, refUbe, refMbe, refSbe} <= '0;
      refFs      <= 2'b00;
      refMpp     <= privUser;
      refMode    <= privMachine;
      refMedeleg <= '0;
    end else if (!stall) begin
      if (trap) begin
        if (trapTarget == privMachine) begin
          refMpie <= refMie;
          refMie  <= 1'b0;
          refMpp  <= refMode;
        end else begin
          refSpie <= refSie;
          refSie  <= 1'b0;
          refSpp  <= (refMode == privSuper);
        end
        refMode <= trapTarget;
      end else if (mret) begin
        refMie  <= refMpie;
        refMpie <= 1'b1;
        refMpp  <= privUser; // lowest mode with u supported
        refMprv <= refMprv && (refMpp == privMachine);
        refMode <= refMpp;
      end else if (sret) begin
        refSie  <= refSpie;
        refSpie <= 1'b1;
        refSpp  <= 1'b0;
        refMprv <= 1'b0;
        refMode <= refSpp ? privSuper : privUser;
      end else if (expWrite && csrAddr == addrMstatus) begin
        {refTsr, refTw, refTvm, refMxr, refSum} <= {wv.ms.tsr, wv.ms.tw, wv.ms.tvm,
                                                     wv.ms.mxr, wv.ms.sum};
        refMprv <= wv.ms.mprv;
        refFs   <= wv.ms.fs;
        refMpp  <= (wv.ms.mpp == 2'b10) ? privMachine : wv.ms.mpp; // warl
        {refSpp, refMpie, refSpie, refMie, refSie} <= {wv.ms.spp, wv.ms.mpie, wv.ms.spie,
                                                       wv.ms.mie, wv.ms.sie};
        refUbe  <= wv.ms.ube;
      end else if (expWrite && csrAddr == addrMstatush) begin
        refMbe <= wv.msh.mbe;
        refSbe <= wv.msh.sbe;
      end else if (expWrite && csrAddr == addrSstatus) begin
        {refMxr, refSum, refFs} <= {wv.ms.mxr, wv.ms.sum, wv.ms.fs};
        {refSpp, refSpie, refSie, refUbe} <= {wv.ms.spp, wv.ms.spie, wv.ms.sie, wv.ms.ube};
      end else if (fpWrite) begin
        refFs <= fsDirty;
      end
      if (expWrite && csrAddr == addrMedeleg) refMedeleg <= expWval & ~32'h800; // bit 11 fixed
    end
  end

  ////////////////////
  // checks
  ////////////////////

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
    errors++;
    $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, expected);
  endtask

  rdataCheck: assert property (@(posedge clk) disable iff (reset) csrRdata == expRead)
    else begin
      errors++;
      $display("** Error at %0t: csrRdata = %h, expected %h", $time, $sampled(csrRdata),
               $sampled(expRead));
    end
  modeCheck: assert property (@(posedge clk) disable iff (reset) privMode == refMode)
    else begin
      errors++;
      $display("** Error at %0t: privMode = %b, expected %b", $time, $sampled(privMode),
               $sampled(refMode));
    end
  endianCheck: assert property (@(posedge clk) disable iff (reset) bigEndian == expBe)
    else begin
      errors++;
      $display("** Error at %0t: bigEndian = %b, expected %b", $time, $sampled(bigEndian),
               $sampled(expBe));
    end
  illegalCheck: assert property (@(posedge clk) disable iff (reset) illegalCsr == expIllegal)
    else begin
      errors++;
      $display("** Error at %0t: illegalCsr = %b, expected %b", $time, $sampled(illegalCsr),
               $sampled(expIllegal));
    end

  // full status words on their own ports
  mstatusCheck: assert property (@(posedge clk) disable iff (reset) mstatusWord == expMs)
    else reportMismatch("mstatusWord", $sampled(mstatusWord), $sampled(expMs));
  mstatushCheck: assert property (@(posedge clk) disable iff (reset) mstatushWord == expMsh)
    else reportMismatch("mstatushWord", $sampled(mstatushWord), $sampled(expMsh));
  sstatusCheck: assert property (@(posedge clk) disable iff (reset) sstatusWord == expSs)
    else reportMismatch("sstatusWord", $sampled(sstatusWord), $sampled(expSs));

  // field levels
  mieCheck: assert property (@(posedge clk) disable iff (reset) statusMie == refMie)
    else reportMismatch("statusMie", 32'($sampled(statusMie)), 32'($sampled(refMie)));
  sieCheck: assert property (@(posedge clk) disable iff (reset) statusSie == refSie)
    else reportMismatch("statusSie", 32'($sampled(statusSie)), 32'($sampled(refSie)));
  mprvCheck: assert property (@(posedge clk) disable iff (reset) statusMprv == refMprv)
    else reportMismatch("statusMprv", 32'($sampled(statusMprv)), 32'($sampled(refMprv)));
  mppCheck: assert property (@(posedge clk) disable iff (reset) statusMpp == refMpp)
    else reportMismatch("statusMpp", 32'($sampled(statusMpp)), 32'($sampled(refMpp)));
  fsCheck: assert property (@(posedge clk) disable iff (reset) statusFs == refFs)
    else reportMismatch("statusFs", 32'($sampled(statusFs)), 32'($sampled(refFs)));

  ////////////////////
  // stimulus
  ////////////////////

  // each task starts at a falling edge and holds its strobe one cycle
  task automatic accessCsr(input csrOp_t op, input logic [11:0] addr, input logic [31:0] src);
    csrValid = 1'b1;
    csrOp    = op;
    csrAddr  = addr; // left in place so the read mux keeps being checked
    csrSrc   = src;
    @(negedge clk);
    csrValid = 1'b0;
    csrOp    = opNone;
    csrSrc   = '0;
  endtask

  task automatic raiseTrap(input logic [4:0] code);
    trap  = 1'b1;
    cause = code;
    @(negedge clk);
    trap  = 1'b0;
  endtask

  task automatic returnMret();
    mret = 1'b1;
    @(negedge clk);
    mret = 1'b0;
  endtask

  task automatic returnSret();
    sret = 1'b1;
    @(negedge clk);
    sret = 1'b0;
  endtask

  task automatic markFpDirty();
    fpWrite = 1'b1;
    @(negedge clk);
    fpWrite = 1'b0;
  endtask

  initial begin
    logic [31:0] r, src;
    logic [11:0] addr;
    errors   = 0;
    lcgState = 32'hbc04;
    {reset, csrValid, trap, mret, sret, fpWrite, stall, hptwAccess} = 8'b1000_0000;
    csrOp   = opNone;
    csrAddr = addrMstatus;
    csrSrc  = '0;
    cause   = '0;
    repeat (resetCycles) @(negedge clk);
    reset = 1'b0;

    // random csr traffic in machine mode
    for (int i = 0; i < randomOps; i++) begin
      r = nextRand();
      case (r[3:2])
        2'd0:    addr = addrMstatus;
        2'd1:    addr = addrMstatush;
        default: addr = addrSstatus;
      endcase
      src = nextRand();
      if (r[5:4] == 2'd0) src = '0; // zero source so set and clear must not write
      accessCsr(csrOp_t'(r[1:0]), addr, src);
    end
    accessCsr(opWrite, addrMstatus, 32'h0000_1000); // mpp = 10 reads back as machine
    accessCsr(opSet, addrMstatus, 32'h0);
    accessCsr(opNone, addrSstatus, 32'h0);

    // undelegated trap from user and the mret back
    accessCsr(opWrite, addrMstatus, 32'h0000_0088); // mpie, mie, mpp user
    returnMret();
    raiseTrap(5'd2);
    returnMret();
    // user mode poking machine csrs and unknown addresses
    accessCsr(opWrite, addrMstatus, 32'hffff_ffff);
    accessCsr(opSet, addrSstatus, 32'h0000_0002);
    accessCsr(opWrite, 12'h045, 32'h1);
    accessCsr(opNone, addrMstatus, 32'h0);
    raiseTrap(5'd2);
    accessCsr(opWrite, 12'h3ff, 32'h1); // unknown even for machine

    // delegated ecall from user
    accessCsr(opWrite, addrMedeleg, 32'h0000_0900); // bit 11 must stay 0
    accessCsr(opNone, addrMedeleg, 32'h0);
    accessCsr(opWrite, addrMstatus, 32'h0000_0002);
    returnMret();
    csrAddr = addrSstatus;
    raiseTrap(5'd8);
    returnSret();
    raiseTrap(5'd8);
    accessCsr(opSet, addrSstatus, 32'h0000_0100); // spp set from s mode
    raiseTrap(5'd2);
    raiseTrap(5'd8);                              // machine stays machine
    returnMret();
    accessCsr(opWrite, addrMstatus, 32'h0000_0900); // mpp s, spp
    returnMret();
    returnSret();                                   // s back to s
    raiseTrap(5'd2);

    // fp dirty and sd
    accessCsr(opClear, addrMstatus, 32'h0000_6000);
    markFpDirty();
    accessCsr(opNone, addrSstatus, 32'h0);
    accessCsr(opNone, addrMstatus, 32'h0);

    // endianness across modes, mprv and the page walker
    for (int i = 0; i < endianRounds; i++) begin
      accessCsr(opWrite, addrMstatush, nextRand());
      accessCsr(opWrite, addrMstatus, nextRand());
      r = nextRand();
      hptwAccess = r[0];
      @(negedge clk);
      hptwAccess = 1'b0;
      returnMret();
      hptwAccess = r[1];
      @(negedge clk);
      hptwAccess = 1'b0;
      raiseTrap(5'd2);
    end

    // stall freezes everything
    stall = 1'b1;
    raiseTrap(5'd2);
    accessCsr(opWrite, addrMstatus, 32'hffff_ffff);
    markFpDirty();
    returnMret();
    stall = 1'b0;
    repeat (2) @(negedge clk);

    $display("checks finished with %0d errors", errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // watchdog
  initial begin
    #(watchdogTime);
    $display("timeout: the stimulus did not finish within %0d time units", watchdogTime);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/csrUnit.sv
`default_nettype none

module csrUnit #(
  parameter bit sSupported         = 1'b1,
  parameter bit uSupported         = 1'b1,
  parameter bit fpSupported        = 1'b1,
  parameter bit bigEndianSupported = 1'b1
) (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               csrValid,
  input  wire privPkg::csrOp_t    csrOp,
  input  wire logic [11:0]        csrAddr,
  input  wire logic [31:0]        csrSrc,
  input  wire logic               trap,
  input  wire logic [4:0]         cause,
  input  wire logic               mret,
  input  wire logic               sret,
  input  wire logic               fpWrite,
  input  wire logic               stall,
  input  wire logic               hptwAccess,
  output logic [31:0]             csrRdata,
  output logic                    illegalCsr,
  output privPkg::privMode_t      privMode,
  output logic [31:0]             mstatusWord,
  output logic [31:0]             mstatushWord,
  output logic [31:0]             sstatusWord,
  output logic                    statusMie,
  output logic                    statusSie,
  output logic                    statusMprv,
  output privPkg::privMode_t      statusMpp,
  output logic [1:0]              statusFs,
  output logic                    bigEndian
);

  import privPkg::*;

  privMode_t   nextPrivMode;          // trap target
  logic        writeMstatus, writeMstatush, writeSstatus, writeMedeleg;
  logic [31:0] writeVal, medelegWord; // combined csr write value

  ////////////////////
  // blocks
  ////////////////////

  statusReg #(
    .sSupported(sSupported), .uSupported(uSupported),
    .fpSupported(fpSupported), .bigEndianSupported(bigEndianSupported)
  ) u_statusReg (
    .clk, .reset, .stall, .trap, .mret, .sret, .fpWrite, .hptwAccess,
    .writeMstatus, .writeMstatush, .writeSstatus, .writeVal,
    .privMode, .nextPrivMode,
    .mstatusWord, .mstatushWord, .sstatusWord,
    .statusMie, .statusSie, .statusMprv, .statusMpp, .statusFs, .bigEndian
  );

  privTracker #(.sSupported(sSupported)) u_privTracker (
    .clk, .reset, .stall, .trap, .mret, .sret, .cause,
    .writeMedeleg, .writeVal,
    .statusMpp,
    .statusSpp(mstatusWord[8]), // spp straight from the mstatus view
    .privMode, .nextPrivMode, .medelegWord
  );

  csrAccess #(.sSupported(sSupported)) u_csrAccess (
    .csrValid, .csrOp, .csrAddr, .csrSrc,
    .privMode, .mstatusWord, .mstatushWord, .sstatusWord, .medelegWord,
    .csrRdata, .illegalCsr,
    .writeMstatus, .writeMstatush, .writeSstatus, .writeMedeleg, .writeVal
  );

endmodule

`default_nettype wire

//--- source/csrAccess.sv
`default_nettype none

module csrAccess #(
  parameter bit sSupported = 1'b1
) (
  input  wire logic               csrValid,
  input  wire privPkg::csrOp_t    csrOp,
  input  wire logic [11:0]        csrAddr,
  input  wire logic [31:0]        csrSrc,
  input  wire privPkg::privMode_t privMode,
  input  wire logic [31:0]        mstatusWord,
  input  wire logic [31:0]        mstatushWord,
  input  wire logic [31:0]        sstatusWord,
  input  wire logic [31:0]        medelegWord,
  output logic [31:0]             csrRdata,
  output logic                    illegalCsr,
  output logic                    writeMstatus,
  output logic                    writeMstatush,
  output logic                    writeSstatus,
  output logic                    writeMedeleg,
  output logic [31:0]             writeVal
);

  import privPkg::*;

  logic hitMstatus, hitMstatush, hitSstatus, hitMedeleg;
  logic known, tooLow, sCsr, doWrite;

  ////////////////////
  // address decode
  ////////////////////

  assign hitMstatus  = (csrAddr == addrMstatus);
  assign hitMstatush = (csrAddr == addrMstatush);
  assign hitSstatus  = (csrAddr == addrSstatus);
  assign hitMedeleg  = (csrAddr == addrMedeleg);
  assign known       = hitMstatus | hitMstatush | hitSstatus | hitMedeleg;

  assign tooLow = (privMode < csrAddr[9:8]); // addr bits 9:8 give min mode
  assign sCsr   = (csrAddr[9:8] == privSuper);

  assign illegalCsr = csrValid & (~known | tooLow | (sCsr & ~sSupported));

  // read mux, unknown addresses read 0
  always_comb begin
    case (1'b1)
      hitMstatus:  csrRdata = mstatusWord;
      hitMstatush: csrRdata = mstatushWord;
      hitSstatus:  csrRdata = sstatusWord;
      hitMedeleg:  csrRdata = medelegWord;
      default:     csrRdata = '0;
    endcase
  end

  ////////////////////
  // write value
  ////////////////////

  always_comb begin
    case (csrOp)
      opWrite: writeVal = csrSrc;
      opSet:   writeVal = csrRdata | csrSrc;
      opClear: writeVal = csrRdata & ~csrSrc;
      default: writeVal = csrRdata; // plain read
    endcase
  end

  // csrrs/csrrc with zero source is a pure read
  assign doWrite = csrValid & ~illegalCsr &
                   ((csrOp == opWrite) | ((csrOp != opNone) & (csrSrc != '0)));

  assign writeMstatus  = doWrite & hitMstatus;
  assign writeMstatush = doWrite & hitMstatush;
  assign writeSstatus  = doWrite & hitSstatus;
  assign writeMedeleg  = doWrite & hitMedeleg;

endmodule

`default_nettype wire

//--- source/privTracker.sv
`default_nettype none

module privTracker #(
  parameter bit sSupported = 1'b1
) (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               stall,
  input  wire logic               trap,
  input  wire logic               mret,
  input  wire logic               sret,
  input  wire logic [4:0]         cause,
  input  wire logic               writeMedeleg,
  input  wire logic [31:0]        writeVal,
  input  wire privPkg::privMode_t statusMpp,
  input  wire logic               statusSpp,
  output privPkg::privMode_t      privMode,
  output privPkg::privMode_t      nextPrivMode,
  output logic [31:0]             medelegWord
);

  import privPkg::*;

  // bit 11 is ecall from m, which can never be delegated
  localparam logic [31:0] medelegMask = sSupported ? 32'hffff_f7ff : 32'h0;

  privMode_t   modeReg;
  logic [31:0] medelegReg;

  ////////////////////
  // trap target
  ////////////////////

  always_comb begin
    if (sSupported && modeReg != privMachine && medelegReg[cause])
      nextPrivMode = privSuper;
    else
      nextPrivMode = privMachine; // machine traps never drop down
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      modeReg    <= privMachine;
      medelegReg <= '0;
    end else if (!stall) begin
      if (trap)      modeReg <= nextPrivMode;
      else if (mret) modeReg <= statusMpp;
      else if (sret) modeReg <= statusSpp ? privSuper : privUser;
      if (writeMedeleg) medelegReg <= writeVal & medelegMask;
    end
  end

  assign privMode    = modeReg;
  assign medelegWord = medelegReg;

  // decode above us is expected to trap sret from u mode instead
  sretFromUser: assert property (@(posedge clk) disable iff (reset)
    (sret && !stall) |-> (modeReg != privUser))
    else $error("sret accepted in user mode");

endmodule

`default_nettype wire

//--- source/statusReg.sv
`default_nettype none

module statusReg #(
  parameter bit sSupported         = 1'b1,
  parameter bit uSupported         = 1'b1,
  parameter bit fpSupported        = 1'b1,
  parameter bit bigEndianSupported = 1'b1
) (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               stall,
  input  wire logic               trap,
  input  wire logic               mret,
  input  wire logic               sret,
  input  wire logic               fpWrite,
  input  wire logic               hptwAccess,
  input  wire logic               writeMstatus,
  input  wire logic               writeMstatush,
  input  wire logic               writeSstatus,
  input  wire logic [31:0]        writeVal,
  input  wire privPkg::privMode_t privMode,
  input  wire privPkg::privMode_t nextPrivMode,
  output logic [31:0]             mstatusWord,
  output logic [31:0]             mstatushWord,
  output logic [31:0]             sstatusWord,
  output logic                    statusMie,
  output logic                    statusSie,
  output logic                    statusMprv,
  output privPkg::privMode_t      statusMpp,
  output logic [1:0]              statusFs,
  output logic                    bigEndian
);

  import privPkg::*;
  import statusPkg::*;

  // raw field storage, some bits are masked again on the way out
  logic       tsrInt, twInt, tvmInt, mxrInt, sumInt, mprvInt;
  logic [1:0] fsInt;
  privMode_t  mppReg, mppNext;
  logic       sppReg, mpieReg, spieReg, mieReg, sieReg;
  logic       mbeReg, sbeReg, ubeReg;

  // visible fields after warl masking
  logic       tsr, tw, tvm, mxr, sum, mprv, sd;
  logic [1:0] fs;

  statusWord_u wrVal, mWord, hWord, sWord;

  assign wrVal = writeVal; // one word, decoded as mstatus or mstatush

  assign tsr  = sSupported & tsrInt;
  assign tw   = (sSupported | uSupported) & twInt; // no lower mode, no wfi trap
  assign tvm  = sSupported & tvmInt;
  assign mxr  = sSupported & mxrInt;
  assign sum  = sSupported & sumInt;
  assign mprv = uSupported & mprvInt;
  assign fs   = fpSupported ? fsInt : fsOff;
  assign sd   = (fs == fsDirty); // xs is hardwired off

  // illegal or unsupported mpp values fall back to machine
  always_comb begin
    if (wrVal.ms.mpp == privUser && uSupported)       mppNext = privUser;
    else if (wrVal.ms.mpp == privSuper && sSupported) mppNext = privSuper;
    else                                              mppNext = privMachine;
  end

  ////////////////////
  // read views
  ////////////////////

  always_comb begin
    mWord         = '0;
    mWord.ms.sd   = sd;
    mWord.ms.tsr  = tsr;
    mWord.ms.tw   = tw;
    mWord.ms.tvm  = tvm;
    mWord.ms.mxr  = mxr;
    mWord.ms.sum  = sum;
    mWord.ms.mprv = mprv;
    mWord.ms.fs   = fs;
    mWord.ms.mpp  = mppReg;
    mWord.ms.spp  = sppReg;
    mWord.ms.mpie = mpieReg;
    mWord.ms.ube  = ubeReg;
    mWord.ms.spie = spieReg;
    mWord.ms.mie  = mieReg;
    mWord.ms.sie  = sieReg;
    // sstatus is a subset, machine-only fields read 0
    sWord         = '0;
    sWord.ms.sd   = sd;
    sWord.ms.mxr  = mxr;
    sWord.ms.sum  = sum;
    sWord.ms.fs   = fs;
    sWord.ms.spp  = sppReg;
    sWord.ms.ube  = ubeReg;
    sWord.ms.spie = spieReg;
    sWord.ms.sie  = sieReg;
    hWord         = '0;
    hWord.msh.mbe = mbeReg;
    hWord.msh.sbe = sbeReg;
  end

  assign mstatusWord  = mWord;
  assign mstatushWord = hWord;
  assign sstatusWord  = sWord;

  assign statusMie  = mieReg;
  assign statusSie  = sieReg;
  assign statusMprv = mprv;
  assign statusMpp  = mppReg;
  assign statusFs   = fs;

  ////////////////////
  // field updates
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      tsrInt  <= 1'b0;
      twInt   <= 1'b0;
      tvmInt  <= 1'b0;
      mxrInt  <= 1'b0;
      sumInt  <= 1'b0;
      mprvInt <= 1'b0;
      fsInt   <= fsOff;
      mppReg  <= privUser; // 00
      sppReg  <= 1'b0;
      mpieReg <= 1'b0;
      spieReg <= 1'b0;
      mieReg  <= 1'b0;
      sieReg  <= 1'b0;
      mbeReg  <= 1'b0;
      sbeReg  <= 1'b0;
      ubeReg  <= 1'b0;
    end else if (!stall) begin
      if (trap) begin
        if (nextPrivMode == privMachine) begin
          mpieReg <= mieReg;
          mieReg  <= 1'b0;
          mppReg  <= privMode;
        end else begin // delegated to s mode
          spieReg <= sieReg;
          sieReg  <= 1'b0;
          sppReg  <= privMode[0];
        end
      end else if (mret) begin
        mieReg  <= mpieReg;
        mpieReg <= 1'b1;
        mppReg  <= uSupported ? privUser : privMachine; // lowest supported mode
        mprvInt <= mprvInt & (mppReg == privMachine);
      end else if (sret) begin
        sieReg  <= spieReg;
        spieReg <= sSupported;
        sppReg  <= 1'b0;
        mprvInt <= 1'b0;
      end else if (writeMstatus) begin
        tsrInt  <= wrVal.ms.tsr;
        twInt   <= wrVal.ms.tw;
        tvmInt  <= wrVal.ms.tvm;
        mxrInt  <= wrVal.ms.mxr;
        sumInt  <= wrVal.ms.sum;
        mprvInt <= wrVal.ms.mprv;
        fsInt   <= wrVal.ms.fs;
        mppReg  <= mppNext;
        sppReg  <= sSupported & wrVal.ms.spp;
        mpieReg <= wrVal.ms.mpie;
        spieReg <= sSupported & wrVal.ms.spie;
        mieReg  <= wrVal.ms.mie;
        sieReg  <= sSupported & wrVal.ms.sie;
        ubeReg  <= uSupported & bigEndianSupported & wrVal.ms.ube;
      end else if (writeMstatush) begin
        mbeReg <= bigEndianSupported & wrVal.msh.mbe;
        sbeReg <= sSupported & bigEndianSupported & wrVal.msh.sbe;
      end else if (writeSstatus) begin
        mxrInt  <= wrVal.ms.mxr;
        sumInt  <= wrVal.ms.sum;
        fsInt   <= wrVal.ms.fs;
        sppReg  <= sSupported & wrVal.ms.spp;
        spieReg <= sSupported & wrVal.ms.spie;
        sieReg  <= sSupported & wrVal.ms.sie;
        ubeReg  <= uSupported & bigEndianSupported & wrVal.ms.ube;
      end else if (fpWrite) begin
        fsInt <= fsDirty;
      end
    end
  end

  ////////////////////
  // data endianness
  ////////////////////

  if (bigEndianSupported) begin : genEndian
    privMode_t endianMode;
    always_comb begin
      if (hptwAccess)                          endianMode = privSuper; // page walker
      else if (privMode == privMachine && mprv) endianMode = mppReg;
      else                                     endianMode = privMode;
      case (endianMode)
        privMachine: bigEndian = mbeReg;
        privSuper:   bigEndian = sbeReg;
        default:     bigEndian = ubeReg;
      endcase
    end
  end else begin : genLittle
    assign bigEndian = 1'b0; // little endian only
  end

  // csr decode must never name two status views at once
  strobeOneHot: assert property (@(posedge clk) disable iff (reset)
    $onehot0({writeMstatus, writeMstatush, writeSstatus}))
    else $error("status write strobes overlap");

  mppLegal: assert property (@(posedge clk) disable iff (reset) mppReg != 2'b10)
    else $error("mpp holds reserved mode 10");

endmodule

`default_nettype wire

//--- source/statusPkg.sv
`default_nettype none

package statusPkg;

  // fs/xs encoding, only off and dirty are named
  localparam logic [1:0] fsOff   = 2'b00;
  localparam logic [1:0] fsDirty = 2'b11;

  // mstatus layout, msb first
  typedef struct packed {
    logic       sd;        // 31
    logic [7:0] rsvd30_23;
    logic       tsr;       // 22
    logic       tw;
    logic       tvm;
    logic       mxr;
    logic       sum;
    logic       mprv;      // 17
    logic [1:0] xs;        // 16:15
    logic [1:0] fs;        // 14:13
    logic [1:0] mpp;       // 12:11
    logic [1:0] rsvd10_9;
    logic       spp;       // 8
    logic       mpie;
    logic       ube;
    logic       spie;      // 5
    logic       rsvd4;
    logic       mie;       // 3
    logic       rsvd2;
    logic       sie;       // 1
    logic       rsvd0;
  } mstatusView_t;

  // mstatush layout, only the two endian bits live here
  typedef struct packed {
    logic [25:0] rsvd31_6;
    logic        mbe;      // 5
    logic        sbe;      // 4
    logic [3:0]  rsvd3_0;
  } mstatushView_t;

  // same 32-bit word seen as either half of the status register
  typedef union packed {
    mstatusView_t  ms;
    mstatushView_t msh;
  } statusWord_u;

endpackage

`default_nettype wire

//--- source/privPkg.sv
`default_nettype none

package privPkg;

  ////////////////////
  // privilege modes
  ////////////////////

  typedef logic [1:0] privMode_t;

  localparam privMode_t privUser    = 2'b00;
  localparam privMode_t privSuper   = 2'b01;
  localparam privMode_t privMachine = 2'b11; // 10 is reserved (hypervisor)

  ////////////////////
  // csr operations and addresses
  ////////////////////

  typedef enum logic [1:0] {
    opNone  = 2'b00, // read only
    opWrite = 2'b01, // csrrw
    opSet   = 2'b10, // csrrs
    opClear = 2'b11  // csrrc
  } csrOp_t;

  localparam logic [11:0] addrSstatus  = 12'h100;
  localparam logic [11:0] addrMstatus  = 12'h300;
  localparam logic [11:0] addrMedeleg  = 12'h302;
  localparam logic [11:0] addrMstatush = 12'h310; // rv32 upper half of mstatus

endpackage

`default_nettype wire
